// File: design/atc_pkg.sv
package atc_pkg;

  // AXI3 write path widths.
  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;
  localparam int USER_W = 1;

  // Command queue sizing.
  localparam int QUEUE_LOG   = 4;
  localparam int QUEUE_DEPTH = 2 ** QUEUE_LOG;
  localparam int CMD_W       = ID_W + 1;  // {check, id}.

  // Optimized write is one 32-byte line as 4 beats of 8 bytes.
  localparam logic [2:0] OPT_SIZE      = 3'd3;
  localparam logic [3:0] OPT_LEN       = 4'd3;
  localparam int         LINE_OFFSET_W = 5;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

endpackage

// File: design/atc_cmd_if.sv
`timescale 1ns/1ps

interface atc_cmd_if
  import atc_pkg::*;
  ();

  logic            valid;
  logic            ready;  // Pop strobe from the consumer.
  logic [ID_W-1:0] id;
  logic            check;

  modport producer (
    output valid,
    output id,
    output check,
    input  ready
  );

  modport consumer (
    input  valid,
    input  id,
    input  check,
    output ready
  );

endinterface

// File: design/wr_addr_check.sv
`timescale 1ns/1ps

module wr_addr_check
  import atc_pkg::*;
  (
  input  logic              ACLK,
  input  logic              ARESET,

  input  logic [ID_W-1:0]   S_AWID,
  input  logic [ADDR_W-1:0] S_AWADDR,
  input  logic [3:0]        S_AWLEN,
  input  logic [2:0]        S_AWSIZE,
  input  logic [1:0]        S_AWBURST,
  input  logic [1:0]        S_AWLOCK,
  input  logic [3:0]        S_AWCACHE,
  input  logic [2:0]        S_AWPROT,
  input  logic [USER_W-1:0] S_AWUSER,
  input  logic              S_AWVALID,
  output logic              S_AWREADY,

  output logic [ID_W-1:0]   M_AWID,
  output logic [ADDR_W-1:0] M_AWADDR,
  output logic [3:0]        M_AWLEN,
  output logic [2:0]        M_AWSIZE,
  output logic [1:0]        M_AWBURST,
  output logic [1:0]        M_AWLOCK,
  output logic [3:0]        M_AWCACHE,
  output logic [2:0]        M_AWPROT,
  output logic [USER_W-1:0] M_AWUSER,
  output logic              M_AWVALID,
  input  logic              M_AWREADY,

  input  logic              resp_done,
  atc_cmd_if.producer       cmd_w
);

  burst_e               burst;
  logic                 is_coherent;
  logic                 is_line_size;
  logic                 is_aligned;
  logic                 is_optimized;

  logic                 push;
  logic                 pop;
  logic                 full;
  logic [QUEUE_LOG:0]   out_cnt;
  logic [QUEUE_LOG-1:0] rd_ptr;
  logic                 cmd_valid_q;
  logic [CMD_W-1:0]     queue_q [QUEUE_DEPTH];

  // Classification of the write on the slave side.
  assign burst        = burst_e'(S_AWBURST);
  assign is_coherent  = S_AWUSER[0] & S_AWCACHE[1];
  assign is_line_size = (S_AWSIZE == OPT_SIZE) & (S_AWLEN == OPT_LEN);
  assign is_aligned   = (S_AWADDR[LINE_OFFSET_W-1:0] == '0);

  always_comb begin
    case (burst)
      BURST_INCR: is_optimized = is_coherent & is_line_size & is_aligned;
      BURST_WRAP: is_optimized = is_coherent & is_line_size;  // Wraps inside the line.
      default:    is_optimized = 1'b0;
    endcase
  end

  assign push = S_AWVALID & M_AWREADY & ~full;
  assign pop  = cmd_valid_q & cmd_w.ready;

  // Writes accepted but not yet answered on B.
  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      out_cnt <= '0;
    end else begin
      case ({push, resp_done})
        2'b10:   out_cnt <= out_cnt + 1'b1;
        2'b01:   out_cnt <= out_cnt - 1'b1;
        default: out_cnt <= out_cnt;
      endcase
    end
  end

  assign full = (out_cnt == QUEUE_DEPTH);

  // Read pointer sits at all ones when the queue is empty.
  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      rd_ptr      <= '1;
      cmd_valid_q <= 1'b0;
    end else begin
      if (push & ~pop) begin
        rd_ptr      <= rd_ptr + 1'b1;
        cmd_valid_q <= 1'b1;
      end else if (~push & pop) begin
        rd_ptr      <= rd_ptr - 1'b1;
        cmd_valid_q <= (rd_ptr != '0);  // Last entry leaving.
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (push) begin
      for (int i = QUEUE_DEPTH - 1; i > 0; i--) begin
        queue_q[i] <= queue_q[i-1];
      end
      queue_q[0] <= {is_optimized, S_AWID};
    end
  end

  assign cmd_w.valid               = cmd_valid_q;
  assign {cmd_w.check, cmd_w.id}   = queue_q[rd_ptr];

  assign M_AWVALID = S_AWVALID & ~full;
  assign S_AWREADY = M_AWREADY & ~full;

  assign M_AWID    = S_AWID;
  assign M_AWADDR  = S_AWADDR;
  assign M_AWLEN   = S_AWLEN;
  assign M_AWSIZE  = S_AWSIZE;
  assign M_AWBURST = S_AWBURST;
  assign M_AWLOCK  = S_AWLOCK;
  assign M_AWCACHE = S_AWCACHE;
  assign M_AWPROT  = S_AWPROT;
  assign M_AWUSER  = S_AWUSER;

endmodule

// File: design/wr_data_check.sv
`timescale 1ns/1ps

module wr_data_check
  import atc_pkg::*;
  (
  input  logic              ACLK,
  input  logic              ARESET,

  input  logic [DATA_W-1:0] S_WDATA,
  input  logic [STRB_W-1:0] S_WSTRB,
  input  logic              S_WLAST,
  input  logic              S_WVALID,
  output logic              S_WREADY,

  output logic [DATA_W-1:0] M_WDATA,
  output logic [STRB_W-1:0] M_WSTRB,
  output logic              M_WLAST,
  output logic              M_WVALID,
  input  logic              M_WREADY,

  atc_cmd_if.consumer       cmd_w,
  atc_cmd_if.producer       cmd_b
);

  typedef enum logic {
    IDLE,
    BURST
  } state_e;

  state_e               state;
  logic                 partial_q;
  logic                 beat;
  logic                 last_beat;
  logic                 beat_partial;
  logic                 partial_seen;

  logic                 push;
  logic                 pop;
  logic [QUEUE_LOG-1:0] rd_ptr;
  logic                 cmd_valid_q;
  logic [CMD_W-1:0]     queue_q [QUEUE_DEPTH];

  // W may only move once its AW command is known.
  assign beat         = S_WVALID & M_WREADY & cmd_w.valid;
  assign last_beat    = beat & S_WLAST;
  assign beat_partial = ~(&S_WSTRB);
  assign partial_seen = (beat & beat_partial) | ((state == BURST) & partial_q);

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state     <= IDLE;
      partial_q <= 1'b0;
    end else if (beat) begin
      if (S_WLAST) begin
        state     <= IDLE;
      end else begin
        state     <= BURST;
        partial_q <= partial_seen;
      end
    end
  end

  assign cmd_w.ready = last_beat;  // One pulse per burst.

  // Results wait here for the matching B.
  assign push = last_beat;
  assign pop  = cmd_valid_q & cmd_b.ready;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      rd_ptr      <= '1;
      cmd_valid_q <= 1'b0;
    end else begin
      if (push & ~pop) begin
        rd_ptr      <= rd_ptr + 1'b1;
        cmd_valid_q <= 1'b1;
      end else if (~push & pop) begin
        rd_ptr      <= rd_ptr - 1'b1;
        cmd_valid_q <= (rd_ptr != '0);
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (push) begin
      for (int i = QUEUE_DEPTH - 1; i > 0; i--) begin
        queue_q[i] <= queue_q[i-1];
      end
      queue_q[0] <= {cmd_w.check & partial_seen, cmd_w.id};  // Check now means error.
    end
  end

  assign cmd_b.valid             = cmd_valid_q;
  assign {cmd_b.check, cmd_b.id} = queue_q[rd_ptr];

  assign M_WVALID = S_WVALID & cmd_w.valid;
  assign S_WREADY = M_WREADY & cmd_w.valid;

  assign M_WDATA  = S_WDATA;
  assign M_WSTRB  = S_WSTRB;
  assign M_WLAST  = S_WLAST;

endmodule

// File: design/wr_resp_check.sv
`timescale 1ns/1ps

module wr_resp_check
  import atc_pkg::*;
  (
  input  logic            ACLK,
  input  logic            ARESET,

  input  logic [ID_W-1:0] M_BID,
  input  logic [1:0]      M_BRESP,
  input  logic            M_BVALID,
  output logic            M_BREADY,

  output logic [ID_W-1:0] S_BID,
  output logic [1:0]      S_BRESP,
  output logic            S_BVALID,
  input  logic            S_BREADY,

  atc_cmd_if.consumer     cmd_b,
  output logic            resp_done,

  output logic            error_valid,
  output logic [ID_W-1:0] error_id
);

  logic b_hs;
  logic report;

  // B is held back until its W burst has been checked.
  assign S_BVALID = M_BVALID & cmd_b.valid;
  assign M_BREADY = S_BREADY & cmd_b.valid;

  assign S_BID    = M_BID;
  assign S_BRESP  = M_BRESP;

  // Responses arrive in AW order.
  assign b_hs        = M_BVALID & S_BREADY & cmd_b.valid;
  assign cmd_b.ready = b_hs;
  assign resp_done   = b_hs;  // Frees one outstanding slot.

  assign report = b_hs & cmd_b.check;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      error_valid <= 1'b0;
    end else begin
      error_valid <= report;
    end
  end

  always_ff @(posedge ACLK) begin
    if (report) begin
      error_id <= cmd_b.id;
    end
  end

endmodule

// File: design/wr_trans_check.sv
`timescale 1ns/1ps

module wr_trans_check
  import atc_pkg::*;
  (
  input  logic              ACLK,
  input  logic              ARESET,

  input  logic [ID_W-1:0]   S_AWID,
  input  logic [ADDR_W-1:0] S_AWADDR,
  input  logic [3:0]        S_AWLEN,
  input  logic [2:0]        S_AWSIZE,
  input  logic [1:0]        S_AWBURST,
  input  logic [1:0]        S_AWLOCK,
  input  logic [3:0]        S_AWCACHE,
  input  logic [2:0]        S_AWPROT,
  input  logic [USER_W-1:0] S_AWUSER,
  input  logic              S_AWVALID,
  output logic              S_AWREADY,

  input  logic [DATA_W-1:0] S_WDATA,
  input  logic [STRB_W-1:0] S_WSTRB,
  input  logic              S_WLAST,
  input  logic              S_WVALID,
  output logic              S_WREADY,

  output logic [ID_W-1:0]   S_BID,
  output logic [1:0]        S_BRESP,
  output logic              S_BVALID,
  input  logic              S_BREADY,

  output logic [ID_W-1:0]   M_AWID,
  output logic [ADDR_W-1:0] M_AWADDR,
  output logic [3:0]        M_AWLEN,
  output logic [2:0]        M_AWSIZE,
  output logic [1:0]        M_AWBURST,
  output logic [1:0]        M_AWLOCK,
  output logic [3:0]        M_AWCACHE,
  output logic [2:0]        M_AWPROT,
  output logic [USER_W-1:0] M_AWUSER,
  output logic              M_AWVALID,
  input  logic              M_AWREADY,

  output logic [DATA_W-1:0] M_WDATA,
  output logic [STRB_W-1:0] M_WSTRB,
  output logic              M_WLAST,
  output logic              M_WVALID,
  input  logic              M_WREADY,

  input  logic [ID_W-1:0]   M_BID,
  input  logic [1:0]        M_BRESP,
  input  logic              M_BVALID,
  output logic              M_BREADY,

  output logic              error_valid,
  output logic [ID_W-1:0]   error_id
);

  logic resp_done;

  atc_cmd_if cmd_w ();  // AW to W.
  atc_cmd_if cmd_b ();  // W to B.

  wr_addr_check u_addr (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .S_AWID    (S_AWID),
    .S_AWADDR  (S_AWADDR),
    .S_AWLEN   (S_AWLEN),
    .S_AWSIZE  (S_AWSIZE),
    .S_AWBURST (S_AWBURST),
    .S_AWLOCK  (S_AWLOCK),
    .S_AWCACHE (S_AWCACHE),
    .S_AWPROT  (S_AWPROT),
    .S_AWUSER  (S_AWUSER),
    .S_AWVALID (S_AWVALID),
    .S_AWREADY (S_AWREADY),
    .M_AWID    (M_AWID),
    .M_AWADDR  (M_AWADDR),
    .M_AWLEN   (M_AWLEN),
    .M_AWSIZE  (M_AWSIZE),
    .M_AWBURST (M_AWBURST),
    .M_AWLOCK  (M_AWLOCK),
    .M_AWCACHE (M_AWCACHE),
    .M_AWPROT  (M_AWPROT),
    .M_AWUSER  (M_AWUSER),
    .M_AWVALID (M_AWVALID),
    .M_AWREADY (M_AWREADY),
    .resp_done (resp_done),
    .cmd_w     (cmd_w.producer)
  );

  wr_data_check u_data (
    .ACLK     (ACLK),
    .ARESET   (ARESET),
    .S_WDATA  (S_WDATA),
    .S_WSTRB  (S_WSTRB),
    .S_WLAST  (S_WLAST),
    .S_WVALID (S_WVALID),
    .S_WREADY (S_WREADY),
    .M_WDATA  (M_WDATA),
    .M_WSTRB  (M_WSTRB),
    .M_WLAST  (M_WLAST),
    .M_WVALID (M_WVALID),
    .M_WREADY (M_WREADY),
    .cmd_w    (cmd_w.consumer),
    .cmd_b    (cmd_b.producer)
  );

  wr_resp_check u_resp (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .M_BID       (M_BID),
    .M_BRESP     (M_BRESP),
    .M_BVALID    (M_BVALID),
    .M_BREADY    (M_BREADY),
    .S_BID       (S_BID),
    .S_BRESP     (S_BRESP),
    .S_BVALID    (S_BVALID),
    .S_BREADY    (S_BREADY),
    .cmd_b       (cmd_b.consumer),
    .resp_done   (resp_done),
    .error_valid (error_valid),
    .error_id    (error_id)
  );

endmodule

// File: tb/tb_wr_trans_check.sv
`timescale 1ns/1ps

module tb_wr_trans_check
  import atc_pkg::*;
  ();

  logic              ACLK;
  logic              ARESET;
  logic [ID_W-1:0]   S_AWID, M_AWID, S_BID, M_BID, error_id;
  logic [ADDR_W-1:0] S_AWADDR, M_AWADDR;
  logic [3:0]        S_AWLEN, M_AWLEN, S_AWCACHE, M_AWCACHE;
  logic [2:0]        S_AWSIZE, M_AWSIZE, S_AWPROT, M_AWPROT;
  logic [1:0]        S_AWBURST, M_AWBURST, S_AWLOCK, M_AWLOCK, S_BRESP, M_BRESP;
  logic [USER_W-1:0] S_AWUSER, M_AWUSER;
  logic              S_AWVALID, S_AWREADY, M_AWVALID, M_AWREADY;
  logic [DATA_W-1:0] S_WDATA, M_WDATA;
  logic [STRB_W-1:0] S_WSTRB, M_WSTRB;
  logic              S_WLAST, S_WVALID, S_WREADY, M_WLAST, M_WVALID, M_WREADY;
  logic              S_BVALID, S_BREADY, M_BVALID, M_BREADY;
  logic              error_valid;

  // One record per write, in AW order.
  logic [ID_W-1:0]   tx_id [$];
  logic [ADDR_W-1:0] tx_addr [$];
  logic [3:0]        tx_len [$], tx_cache [$];
  logic [2:0]        tx_size [$], tx_prot [$];
  logic [1:0]        tx_burst [$], tx_lock [$];
  logic              tx_user [$], tx_opt [$], tx_part [$];

  integer seed;
  int     num_tx, cycles, failed_tests;
  int     aw_idx, w_idx, w_beat, s_aw_cnt, s_w_cnt, b_cnt, m_wlast_cnt, m_b_idx;
  int     reset_errs, thru_errs, class_errs, false_errs, bp_errs;
  bit     run, hold_bready, aborted, err_due;
  logic   aw_hs, w_hs, b_hs, m_aw_hs, m_w_hs, m_b_hs;
  logic [ID_W-1:0] err_due_id;
  logic [ID_W+ADDR_W+USER_W+17:0] aw_exp, aw_act;  // All AW fields.

  wr_trans_check u_dut (.*);

  always #4 ACLK = ~ACLK;

  // Coherent write of exactly one line.
  function automatic logic predict_opt(input int i);
    logic shape_ok;
    shape_ok = tx_user[i] && tx_cache[i][1] && tx_size[i] == OPT_SIZE && tx_len[i] == OPT_LEN;
    if (tx_burst[i] == BURST_WRAP) begin
      return shape_ok;
    end
    return shape_ok && tx_burst[i] == BURST_INCR && tx_addr[i][LINE_OFFSET_W-1:0] == '0;
  endfunction

  function automatic logic [STRB_W-1:0] pick_strobe();
    logic [2:0] lane;
    lane = 3'($random(seed));
    if (3'($random(seed)) == 3'd0) begin
      return ~(STRB_W'(1) << lane);  // One byte dropped.
    end
    return '1;
  endfunction

  task automatic make_writes();
    logic [3:0]        kind;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        len, cache;
    logic [2:0]        size;
    logic              user;
    burst_e            burst;
    for (int i = 0; i < num_tx; i++) begin
      kind  = 4'($random(seed));
      addr  = $random(seed) & 32'hffff_ffe0;
      len   = OPT_LEN;
      size  = OPT_SIZE;
      burst = kind[0] ? BURST_INCR : BURST_WRAP;
      cache = 4'($random(seed)) | 4'h2;
      user  = 1'b1;
      if (kind[3]) begin  // Spoil one field.
        case (kind[2:0])
          3'd0, 3'd6: begin
            burst     = BURST_INCR;
            addr[4:3] = 2'({$random(seed)} % 3 + 1);
          end
          3'd1, 3'd7: burst = BURST_FIXED;
          3'd2:       size = ($random(seed) & 1) ? 3'd2 : 3'd1;
          3'd3:       len = ($random(seed) & 1) ? 4'd7 : 4'd1;
          3'd4:       cache[1] = 1'b0;
          default:    user = 1'b0;
        endcase
      end
      tx_id.push_back(ID_W'($random(seed)));
      tx_addr.push_back(addr);
      tx_len.push_back(len);
      tx_size.push_back(size);
      tx_burst.push_back(burst);
      tx_lock.push_back(2'($random(seed)));
      tx_cache.push_back(cache);
      tx_prot.push_back(3'($random(seed)));
      tx_user.push_back(user);
      tx_part.push_back(1'b0);
      tx_opt.push_back(predict_opt(i));
    end
  endtask

  task automatic check_quiet();
    if (error_valid !== 1'b0 || M_AWVALID !== 1'b0 || S_BVALID !== 1'b0) begin
      reset_errs++;
      $display("ERROR reset: expected 000, actual %b%b%b", error_valid, M_AWVALID, S_BVALID);
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("test %-16s ok", name);
    end else begin
      failed_tests++;
      $display("test %-16s bad, %0d errors", name, errs);
    end
  endtask

  always @(posedge ACLK) begin
    if (run) begin
      aw_hs   = S_AWVALID & S_AWREADY;
      m_aw_hs = M_AWVALID & M_AWREADY;
      w_hs    = S_WVALID & S_WREADY;
      m_w_hs  = M_WVALID & M_WREADY;
      b_hs    = S_BVALID & S_BREADY;
      m_b_hs  = M_BVALID & M_BREADY;

      if (error_valid !== err_due) begin
        if (error_valid) begin
          false_errs++;
          $display("no_false_errors: error_valid pulsed with no faulty write due");
        end else begin
          class_errs++;
          $display("classification: no error_valid for faulty write id %h", err_due_id);
        end
      end else if (err_due && error_id !== err_due_id) begin
        class_errs++;
        $display("ERROR classification: expected id %h, actual id %h", err_due_id, error_id);
      end
      err_due = b_hs && tx_opt[b_cnt] && tx_part[b_cnt];  // Due on the next edge.
      if (b_hs) begin
        err_due_id = tx_id[b_cnt];
      end

      if (aw_hs !== m_aw_hs || w_hs !== m_w_hs || b_hs !== m_b_hs) begin
        thru_errs++;
        $display("pass_through: handshakes on the slave and master sides disagree");
      end
      if (m_aw_hs) begin
        aw_exp = {tx_id[s_aw_cnt], tx_addr[s_aw_cnt], tx_len[s_aw_cnt], tx_size[s_aw_cnt],
                  tx_burst[s_aw_cnt], tx_lock[s_aw_cnt], tx_cache[s_aw_cnt],
                  tx_prot[s_aw_cnt], tx_user[s_aw_cnt]};
        aw_act = {M_AWID, M_AWADDR, M_AWLEN, M_AWSIZE, M_AWBURST, M_AWLOCK, M_AWCACHE,
                  M_AWPROT, M_AWUSER};
        if (aw_act !== aw_exp) begin
          thru_errs++;
          $display("ERROR pass_through AW: expected %h, actual %h", aw_exp, aw_act);
        end
      end
      if (m_w_hs && {M_WDATA, M_WSTRB, M_WLAST} !== {S_WDATA, S_WSTRB, S_WLAST}) begin
        thru_errs++;
        $display("ERROR pass_through W: expected %h, actual %h",
                 {S_WDATA, S_WSTRB, S_WLAST}, {M_WDATA, M_WSTRB, M_WLAST});
      end
      if (b_hs && {S_BID, S_BRESP} !== {tx_id[b_cnt], M_BRESP}) begin
        thru_errs++;
        $display("ERROR pass_through B: expected %h, actual %h",
                 {tx_id[b_cnt], M_BRESP}, {S_BID, S_BRESP});
      end
      if (s_aw_cnt - b_cnt > QUEUE_DEPTH) begin
        bp_errs++;
        $display("back_pressure: more than %0d writes outstanding", QUEUE_DEPTH);
      end

      if (w_hs && S_WSTRB != '1) begin
        tx_part[s_w_cnt] = 1'b1;
      end
      s_w_cnt     += (w_hs && S_WLAST);
      s_aw_cnt    += aw_hs;
      b_cnt       += b_hs;
      m_wlast_cnt += (m_w_hs && M_WLAST);

      if (!S_AWVALID || aw_hs) begin
        if (aw_idx < num_tx && ($random(seed) & 1)) begin
          S_AWID    <= tx_id[aw_idx];
          S_AWADDR  <= tx_addr[aw_idx];
          S_AWLEN   <= tx_len[aw_idx];
          S_AWSIZE  <= tx_size[aw_idx];
          S_AWBURST <= tx_burst[aw_idx];
          S_AWLOCK  <= tx_lock[aw_idx];
          S_AWCACHE <= tx_cache[aw_idx];
          S_AWPROT  <= tx_prot[aw_idx];
          S_AWUSER  <= tx_user[aw_idx];
          S_AWVALID <= 1'b1;
          aw_idx++;
        end else begin
          S_AWVALID <= 1'b0;
        end
      end
      if (!S_WVALID || w_hs) begin
        if (w_idx < num_tx && ($random(seed) & 3) != 0) begin
          S_WVALID <= 1'b1;
          S_WDATA  <= {$random(seed), $random(seed)};
          S_WSTRB  <= pick_strobe();
          S_WLAST  <= (w_beat == tx_len[w_idx]);
          if (w_beat == tx_len[w_idx]) begin
            w_beat = 0;
            w_idx++;
          end else begin
            w_beat++;
          end
        end else begin
          S_WVALID <= 1'b0;
        end
      end

      // Slave answers in AW order once the burst's last beat is through.
      if (!M_BVALID || m_b_hs) begin
        if (m_b_idx < m_wlast_cnt && ($random(seed) & 1)) begin
          M_BVALID <= 1'b1;
          M_BID    <= tx_id[m_b_idx];
          M_BRESP  <= 2'($random(seed));
          m_b_idx++;
        end else begin
          M_BVALID <= 1'b0;
        end
      end
      M_AWREADY <= ($random(seed) & 3) != 0;
      M_WREADY  <= ($random(seed) & 3) != 0;
      S_BREADY  <= !hold_bready && ($random(seed) & 1);
    end
  end

  initial begin
    seed   = 55147;
    num_tx = 200;
    ACLK   = 1'b0;
    ARESET = 1'b1;
    {S_AWID, S_AWADDR, S_AWLEN, S_AWSIZE, S_AWBURST, S_AWLOCK, S_AWCACHE} = '0;
    {S_AWPROT, S_AWUSER, S_AWVALID, S_WDATA, S_WSTRB, S_WLAST, S_WVALID} = '0;
    {S_BREADY, M_AWREADY, M_WREADY, M_BID, M_BRESP, M_BVALID} = '0;
    make_writes();

    for (int i = 0; i < 5; i++) begin
      @(posedge ACLK);
      if (i > 0) begin
        check_quiet();
      end
    end
    ARESET <= 1'b0;
    repeat (3) begin
      @(posedge ACLK);
      check_quiet();
    end
    report_test("reset", reset_errs);

    @(negedge ACLK);
    run = 1'b1;
    cycles = 0;
    while (b_cnt < 40 && cycles < 5000) begin
      @(negedge ACLK);
      cycles++;
    end
    if (b_cnt < 40) begin
      aborted = 1'b1;
      $display("timeout: only %0d B responses seen before the BREADY stall", b_cnt);
    end
    hold_bready = 1'b1;  // Stall B until the AW side fills up.
    cycles = 0;
    while (s_aw_cnt - b_cnt < QUEUE_DEPTH && cycles < 5000) begin
      @(negedge ACLK);
      cycles++;
    end
    if (s_aw_cnt - b_cnt < QUEUE_DEPTH) begin
      aborted = 1'b1;
      $display("timeout: outstanding writes never reached %0d with BREADY low", QUEUE_DEPTH);
    end
    repeat (100) @(negedge ACLK);
    hold_bready = 1'b0;
    cycles = 0;
    while (b_cnt < num_tx && cycles < 20000) begin
      @(negedge ACLK);
      cycles++;
    end
    if (b_cnt < num_tx) begin
      aborted = 1'b1;
      $display("timeout: only %0d of %0d B responses seen", b_cnt, num_tx);
    end
    repeat (3) @(negedge ACLK);
    report_test("back_pressure", bp_errs);
    report_test("pass_through", thru_errs);
    report_test("classification", class_errs);
    report_test("no_false_errors", false_errs);

    $display("5 tests, %0d failed, %0d errors, %0d timeouts", failed_tests,
             reset_errs + thru_errs + class_errs + false_errs + bp_errs, aborted);
    if (aborted || failed_tests != 0) begin
      $display("*** FAILED ***");
    end else begin
      $display("*** PASSED ***");
    end
    $finish;
  end

endmodule

// File: all.f
design/atc_pkg.sv
design/atc_cmd_if.sv
design/wr_addr_check.sv
design/wr_data_check.sv
design/wr_resp_check.sv
design/wr_trans_check.sv
tb/tb_wr_trans_check.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_wr_trans_check
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
